// ==== src.f ====
hw/vec_alu_pkg.sv
hw/apb_operand_regs.sv
hw/vec_alu.sv
hw/result_stage.sv
hw/vec_alu_top.sv
verif/vec_alu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the vector ALU testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module vec_alu_tb -f src.f -o vec_alu_sim
./obj_dir/vec_alu_sim > sim.log 2>&1
cat sim.log

if grep -q "test failed" sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi
echo "Simulation finished without failures"

// ==== verif/vec_alu_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

module vec_alu_tb;

	localparam int LANES = vec_alu_pkg::LANES;
	localparam int WAIT_MAX = 16;	// Polls before a wait gives up.

	logic clk;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	wire [31:0] prdata;
	wire pready;
	wire pslverr;

	logic [31:0] op_a [LANES];
	logic [31:0] op_b [LANES];
	logic [31:0] res [LANES];
	logic [31:0] rdata;
	int errors;
	int tests_ok;
	int tests_bad;

	vec_alu_top u_dut (
		.clk_i(clk),
		.rst_i(rst),
		.psel_i(psel),
		.penable_i(penable),
		.pwrite_i(pwrite),
		.paddr_i(paddr),
		.pwdata_i(pwdata),
		.prdata_o(prdata),
		.pready_o(pready),
		.pslverr_o(pslverr)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	// One APB transfer. Read data is taken at the falling edge of the access phase.
	task automatic apb_access(input logic write, input logic [7:0] addr, input logic [31:0] data);
		int n;
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
		end
		while (!pready && n < WAIT_MAX);
		if (!pready)
		begin
			$display("APB transfer to address %h never saw pready", addr);
			$display("test failed");
			$finish;
		end
		else
		begin
			rdata = prdata;
			check_value({31'd0, pslverr}, 32'd0, "pslverr");
			@(posedge clk);
			psel <= 1'b0;
			penable <= 1'b0;
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		apb_access(1'b1, addr, data);
	endtask

	task automatic apb_read(input logic [7:0] addr);
		apb_access(1'b0, addr, 32'd0);
	endtask

	task automatic fill_random();
		for (int i = 0; i < LANES; i++)
		begin
			op_a[i] = $urandom;
			op_b[i] = $urandom;
		end
	endtask

	// Load both vectors, start, poll for done and read the whole result back.
	task automatic run_op(input logic [5:0] opc);
		int n;
		for (int i = 0; i < LANES; i++)
		begin
			apb_write(vec_alu_pkg::ADDR_OP1 + 8'(4 * i), op_a[i]);
			apb_write(vec_alu_pkg::ADDR_OP2 + 8'(4 * i), op_b[i]);
		end
		apb_write(vec_alu_pkg::ADDR_OPCODE, {26'd0, opc});
		apb_write(vec_alu_pkg::ADDR_CTRL, 32'd1);
		n = 0;
		do
		begin
			apb_read(vec_alu_pkg::ADDR_STATUS);
			n++;
		end
		while (!rdata[0] && n < WAIT_MAX);
		if (!rdata[0])
		begin
			$display("Opcode %0d never set the done flag", opc);
			$display("test failed");
			$finish;
		end
		else
		begin
			for (int i = 0; i < LANES; i++)
			begin
				apb_read(vec_alu_pkg::ADDR_RESULT + 8'(4 * i));
				res[i] = rdata;
			end
		end
	endtask

	// Expected lane value. Compare stimulus never overflows, so plain signed
	// compares agree with the sign of the wrapped difference.
	function automatic logic [31:0] expect_result(input logic [5:0] opc, input int lane);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] fill;
		logic [15:0] mask;
		a = op_a[lane];
		b = op_b[lane];
		fill = a[31] ? ~(32'hFFFF_FFFF >> b[4:0]) : 32'd0;	// Sign bits shifted in by ASR.
		mask = '0;
		for (int i = 0; i < LANES; i++)
		begin
			case (opc)
				vec_alu_pkg::OP_EQ: mask[i] = op_a[i] == op_b[i];
				vec_alu_pkg::OP_NE: mask[i] = op_a[i] != op_b[i];
				vec_alu_pkg::OP_GT: mask[i] = $signed(op_a[i]) > $signed(op_b[i]);
				vec_alu_pkg::OP_GE: mask[i] = $signed(op_a[i]) >= $signed(op_b[i]);
				vec_alu_pkg::OP_LT: mask[i] = $signed(op_a[i]) < $signed(op_b[i]);
				vec_alu_pkg::OP_LE: mask[i] = $signed(op_a[i]) <= $signed(op_b[i]);
				default: mask[i] = 1'b0;
			endcase
		end
		case (opc)
			vec_alu_pkg::OP_OR: return a | b;
			vec_alu_pkg::OP_AND: return a & b;
			vec_alu_pkg::OP_ANDN: return a & ~b;
			vec_alu_pkg::OP_XOR: return a ^ b;
			vec_alu_pkg::OP_NOT: return ~b;
			vec_alu_pkg::OP_ADD: return a + b;
			vec_alu_pkg::OP_SUB: return a - b;
			vec_alu_pkg::OP_ASR: return (a >> b[4:0]) | fill;
			vec_alu_pkg::OP_LSR: return a >> b[4:0];
			vec_alu_pkg::OP_LSL: return a << b[4:0];
			vec_alu_pkg::OP_EQ, vec_alu_pkg::OP_NE, vec_alu_pkg::OP_GT,
			vec_alu_pkg::OP_GE, vec_alu_pkg::OP_LT, vec_alu_pkg::OP_LE:
				return (lane == 0) ? {16'd0, mask} : 32'd0;
			default: return 32'd0;
		endcase
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got == exp)
		else
		begin
			$display("Fail at %0t: %s read %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_result(input logic [5:0] opc);
		for (int i = 0; i < LANES; i++)
			check_value(res[i], expect_result(opc, i), $sformatf("opcode %0d lane %0d", opc, i));
	endtask

	task automatic end_test(input string name);
		if (errors == 0)
		begin
			$display("%s: ok", name);
			tests_ok++;
		end
		else
		begin
			$display("%s: %0d mismatches", name, errors);
			tests_bad++;
		end
		errors = 0;
	endtask

	initial
	begin
		int base;
		int delta;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		errors = 0;
		tests_ok = 0;
		tests_bad = 0;
		void'($urandom(9));
		repeat (8)
			@(posedge clk);
		rst <= 1'b0;

		apb_read(vec_alu_pkg::ADDR_STATUS);
		check_value(rdata, 32'd0, "status after reset");
		for (int i = 0; i < LANES; i++)
		begin
			apb_read(vec_alu_pkg::ADDR_RESULT + 8'(4 * i));
			check_value(rdata, 32'd0, "result after reset");
		end
		fill_random();
		run_op(vec_alu_pkg::OP_ADD);
		apb_read(vec_alu_pkg::ADDR_STATUS);
		check_value(rdata, 32'h0001_0001, "status after one operation");
		apb_write(vec_alu_pkg::ADDR_OP1, 32'h1234_5678);
		apb_read(vec_alu_pkg::ADDR_STATUS);
		check_value(rdata, 32'h0001_0000, "status after operand write");
		for (int i = 0; i < LANES; i++)
		begin
			apb_read(vec_alu_pkg::ADDR_RESULT + 8'(4 * i));
			check_value(rdata, expect_result(vec_alu_pkg::OP_ADD, i),
				"result held over operand write");
		end
		repeat (3)
		begin
			fill_random();
			run_op(vec_alu_pkg::OP_XOR);
		end
		apb_read(vec_alu_pkg::ADDR_STATUS);
		check_value(rdata, 32'h0004_0001, "status after four operations");
		end_test("reset, done and count");

		for (int op = 0; op < 5; op++)
		begin
			fill_random();
			run_op(6'(op));
			check_result(6'(op));
		end
		end_test("bitwise");

		// Lane 0 wraps on add, lane 1 wraps on subtract.
		for (int k = 0; k < 2; k++)
		begin
			fill_random();
			op_a[0] = 32'hFFFF_FFFF;
			op_b[0] = 32'd1;
			op_a[1] = 32'd0;
			op_b[1] = 32'd1;
			run_op(6'(int'(vec_alu_pkg::OP_ADD) + k));
			check_result(6'(int'(vec_alu_pkg::OP_ADD) + k));
		end
		end_test("add and subtract");

		for (int k = 0; k < 3; k++)
		begin
			fill_random();
			for (int i = 0; i < LANES; i++)
				op_a[i][31] = i[0];	// Odd lanes negative.
			op_b[0] = 32'd32;
			op_b[1] = 32'd63;
			run_op(6'(int'(vec_alu_pkg::OP_ASR) + k));
			check_result(6'(int'(vec_alu_pkg::OP_ASR) + k));
		end
		end_test("shifts");

		for (int i = 0; i < LANES; i++)
		begin
			base = int'($urandom % 32'd1048576) - 524288;
			delta = 1 + int'($urandom % 32'd1000);
			op_b[i] = base;
			op_a[i] = (i % 3 == 0) ? base : (i % 3 == 1) ? base - delta : base + delta;
		end
		for (int op = int'(vec_alu_pkg::OP_EQ); op <= int'(vec_alu_pkg::OP_LE); op++)
		begin
			run_op(6'(op));
			check_result(6'(op));
		end
		end_test("compares");

		for (int k = 0; k < 2; k++)
		begin
			fill_random();
			run_op(6'(k == 0 ? 7 : 63));
			check_result(6'(k == 0 ? 7 : 63));
			apb_read(vec_alu_pkg::ADDR_STATUS);
			check_value({31'd0, rdata[0]}, 32'd1, "done after undefined opcode");
		end
		end_test("undefined opcodes");

		$display("%0d tests ok, %0d tests with mismatches", tests_ok, tests_bad);
		if (tests_bad == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/vec_alu_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module vec_alu_top (
	input wire clk_i,
	input wire rst_i,
	input wire psel_i,
	input wire penable_i,
	input wire pwrite_i,
	input wire [7:0] paddr_i,
	input wire [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o
);

	logic [vec_alu_pkg::VEC_W-1:0] operand1;
	logic [vec_alu_pkg::VEC_W-1:0] operand2;
	logic [vec_alu_pkg::OP_W-1:0] opcode;
	logic start;
	logic clear_done;
	vec_alu_pkg::vec_result_u alu_result;
	vec_alu_pkg::vec_result_u result_q;
	logic done;
	logic [15:0] op_count;

	apb_operand_regs u_regs (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.psel_i(psel_i),
		.penable_i(penable_i),
		.pwrite_i(pwrite_i),
		.paddr_i(paddr_i),
		.pwdata_i(pwdata_i),
		.prdata_o(prdata_o),
		.pready_o(pready_o),
		.pslverr_o(pslverr_o),
		.result_i(result_q),
		.done_i(done),
		.op_count_i(op_count),
		.operand1_o(operand1),
		.operand2_o(operand2),
		.opcode_o(opcode),
		.start_o(start),
		.clear_done_o(clear_done)
	);

	vec_alu u_alu (
		.operation_i(opcode),
		.operand1_i(operand1),
		.operand2_i(operand2),
		.result_o(alu_result)
	);

	result_stage u_result (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.start_i(start),
		.clear_done_i(clear_done),
		.result_i(alu_result),
		.result_o(result_q),
		.done_o(done),
		.op_count_o(op_count)
	);

endmodule

`default_nettype wire

// ==== hw/result_stage.sv ====
`default_nettype none
`timescale 1ns/100ps

module result_stage (
	input wire clk_i,
	input wire rst_i,
	input wire start_i,
	input wire clear_done_i,
	input wire vec_alu_pkg::vec_result_u result_i,
	output vec_alu_pkg::vec_result_u result_o,
	output logic done_o,
	output logic [15:0] op_count_o
);

	vec_alu_pkg::vec_result_u result_q;
	logic done_q;
	logic [15:0] op_count_q;

	// Captured on the edge after the start write, while the operands are still stable.
	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			result_q <= '0;
			done_q <= 1'b0;
			op_count_q <= '0;
		end
		else if (start_i)
		begin
			result_q <= result_i;
			done_q <= 1'b1;
			op_count_q <= op_count_q + 16'd1;	// Wraps after 65535 operations.
		end
		else if (clear_done_i)
		begin
			done_q <= 1'b0;	// Result is kept.
		end
	end

	assign result_o = result_q;
	assign done_o = done_q;
	assign op_count_o = op_count_q;

endmodule

`default_nettype wire

// ==== hw/vec_alu.sv ====
`default_nettype none
`timescale 1ns/100ps

module vec_alu (
	input wire [vec_alu_pkg::OP_W-1:0] operation_i,
	input wire [vec_alu_pkg::VEC_W-1:0] operand1_i,
	input wire [vec_alu_pkg::VEC_W-1:0] operand2_i,
	output vec_alu_pkg::vec_result_u result_o
);

	localparam int SHAMT_W = $clog2(vec_alu_pkg::LANE_W);

	logic [vec_alu_pkg::LANES-1:0][vec_alu_pkg::LANE_W-1:0] op1;
	logic [vec_alu_pkg::LANES-1:0][vec_alu_pkg::LANE_W-1:0] op2;
	logic [vec_alu_pkg::LANES-1:0][vec_alu_pkg::LANE_W-1:0] sum;
	logic [vec_alu_pkg::LANES-1:0][vec_alu_pkg::LANE_W-1:0] difference;
	logic [vec_alu_pkg::LANES-1:0][vec_alu_pkg::LANE_W-1:0] asr;
	logic [vec_alu_pkg::LANES-1:0][vec_alu_pkg::LANE_W-1:0] lsr;
	logic [vec_alu_pkg::LANES-1:0][vec_alu_pkg::LANE_W-1:0] lsl;
	logic [vec_alu_pkg::LANES-1:0] is_equal;
	logic [vec_alu_pkg::LANES-1:0] is_negative;

	assign op1 = operand1_i;
	assign op2 = operand2_i;

	always_comb
	begin
		for (int i = 0; i < vec_alu_pkg::LANES; i++)
		begin
			sum[i] = op1[i] + op2[i];	// Wraps modulo 2^32.
			difference[i] = op1[i] - op2[i];

			// Compare flags come from the wrapped difference, so overflow can flip them.
			is_negative[i] = difference[i][vec_alu_pkg::LANE_W-1];
			is_equal[i] = difference[i] == '0;

			// Only the low bits of each op2 lane give the shift amount.
			asr[i] = $signed(op1[i]) >>> op2[i][SHAMT_W-1:0];
			lsr[i] = op1[i] >> op2[i][SHAMT_W-1:0];
			lsl[i] = op1[i] << op2[i][SHAMT_W-1:0];
		end
	end

	always_comb
	begin
		result_o = '0;
		case (operation_i)
			vec_alu_pkg::OP_OR:
				result_o.lanes = op1 | op2;
			vec_alu_pkg::OP_AND:
				result_o.lanes = op1 & op2;
			vec_alu_pkg::OP_ANDN:
				result_o.lanes = op1 & ~op2;
			vec_alu_pkg::OP_XOR:
				result_o.lanes = op1 ^ op2;
			vec_alu_pkg::OP_NOT:
				result_o.lanes = ~op2;	// Unary on the second operand.
			vec_alu_pkg::OP_ADD:
				result_o.lanes = sum;
			vec_alu_pkg::OP_SUB:
				result_o.lanes = difference;
			vec_alu_pkg::OP_ASR:
				result_o.lanes = asr;
			vec_alu_pkg::OP_LSR:
				result_o.lanes = lsr;
			vec_alu_pkg::OP_LSL:
				result_o.lanes = lsl;

			// Compares pack one bit per lane into the low half word.
			vec_alu_pkg::OP_EQ:
				result_o.cmp.mask = is_equal;
			vec_alu_pkg::OP_NE:
				result_o.cmp.mask = ~is_equal;
			vec_alu_pkg::OP_GT:
				result_o.cmp.mask = ~is_negative & ~is_equal;
			vec_alu_pkg::OP_GE:
				result_o.cmp.mask = ~is_negative;
			vec_alu_pkg::OP_LT:
				result_o.cmp.mask = is_negative;
			vec_alu_pkg::OP_LE:
				result_o.cmp.mask = is_negative | is_equal;
			default:
				result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/apb_operand_regs.sv ====
`default_nettype none
`timescale 1ns/100ps

module apb_operand_regs (
	input wire clk_i,
	input wire rst_i,
	input wire psel_i,
	input wire penable_i,
	input wire pwrite_i,
	input wire [7:0] paddr_i,
	input wire [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	input wire vec_alu_pkg::vec_result_u result_i,
	input wire done_i,
	input wire [15:0] op_count_i,
	output logic [vec_alu_pkg::VEC_W-1:0] operand1_o,
	output logic [vec_alu_pkg::VEC_W-1:0] operand2_o,
	output logic [vec_alu_pkg::OP_W-1:0] opcode_o,
	output logic start_o,
	output logic clear_done_o
);

	localparam int RHI = 7;
	localparam int RLO = vec_alu_pkg::LANE_AW + 2;	// Region bits sit above the lane index.

	logic [vec_alu_pkg::LANES-1:0][vec_alu_pkg::LANE_W-1:0] op1_q;
	logic [vec_alu_pkg::LANES-1:0][vec_alu_pkg::LANE_W-1:0] op2_q;
	logic [vec_alu_pkg::OP_W-1:0] opcode_q;
	logic start_q;
	logic wr_en;
	logic [vec_alu_pkg::LANE_AW-1:0] lane_idx;
	logic sel_op1;
	logic sel_op2;
	logic sel_opcode;
	logic sel_ctrl;
	logic sel_status;
	logic sel_result;

	assign wr_en = psel_i & penable_i & pwrite_i;	// Writes land at the end of the access phase.
	assign lane_idx = paddr_i[RLO-1:2];

	assign sel_op1 = paddr_i[RHI:RLO] == vec_alu_pkg::ADDR_OP1[RHI:RLO];
	assign sel_op2 = paddr_i[RHI:RLO] == vec_alu_pkg::ADDR_OP2[RHI:RLO];
	assign sel_result = paddr_i[RHI:RLO] == vec_alu_pkg::ADDR_RESULT[RHI:RLO];
	assign sel_opcode = paddr_i[RHI:2] == vec_alu_pkg::ADDR_OPCODE[RHI:2];
	assign sel_ctrl = paddr_i[RHI:2] == vec_alu_pkg::ADDR_CTRL[RHI:2];
	assign sel_status = paddr_i[RHI:2] == vec_alu_pkg::ADDR_STATUS[RHI:2];

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			op1_q <= '0;
			op2_q <= '0;
			opcode_q <= '0;
			start_q <= 1'b0;
		end
		else
		begin
			start_q <= wr_en & sel_ctrl & pwdata_i[0];	// High for one cycle only.
			if (wr_en && sel_op1)
				op1_q[lane_idx] <= pwdata_i;
			if (wr_en && sel_op2)
				op2_q[lane_idx] <= pwdata_i;
			if (wr_en && sel_opcode)
				opcode_q <= pwdata_i[vec_alu_pkg::OP_W-1:0];
		end
	end

	// The result stage drops done on the same edge as the write.
	assign clear_done_o = wr_en & (sel_op1 | sel_op2 | sel_opcode);

	always_comb
	begin
		prdata_o = '0;
		if (psel_i)
		begin
			if (sel_op1)
				prdata_o = op1_q[lane_idx];
			else if (sel_op2)
				prdata_o = op2_q[lane_idx];
			else if (sel_result)
				prdata_o = result_i.lanes[lane_idx];
			else if (sel_opcode)
				prdata_o = {{(32 - vec_alu_pkg::OP_W){1'b0}}, opcode_q};
			else if (sel_status)
				prdata_o = {op_count_i, 15'd0, done_i};
		end
	end

	assign operand1_o = op1_q;
	assign operand2_o = op2_q;
	assign opcode_o = opcode_q;
	assign start_o = start_q;
	assign pready_o = 1'b1;	// No wait states.
	assign pslverr_o = 1'b0;

endmodule

`default_nettype wire

// ==== hw/vec_alu_pkg.sv ====
`default_nettype none

package vec_alu_pkg;

	localparam int LANES = 16;
	localparam int LANE_W = 32;
	localparam int VEC_W = LANES * LANE_W;
	localparam int LANE_AW = $clog2(LANES);	// Lane index bits in an address.
	localparam int OP_W = 6;

	// Operation codes. Unlisted codes produce a zero vector.
	localparam logic [OP_W-1:0] OP_OR = 6'd0;
	localparam logic [OP_W-1:0] OP_AND = 6'd1;
	localparam logic [OP_W-1:0] OP_ANDN = 6'd2;
	localparam logic [OP_W-1:0] OP_XOR = 6'd3;
	localparam logic [OP_W-1:0] OP_NOT = 6'd4;
	localparam logic [OP_W-1:0] OP_ADD = 6'd5;
	localparam logic [OP_W-1:0] OP_SUB = 6'd6;
	localparam logic [OP_W-1:0] OP_ASR = 6'd9;
	localparam logic [OP_W-1:0] OP_LSR = 6'd10;
	localparam logic [OP_W-1:0] OP_LSL = 6'd11;
	localparam logic [OP_W-1:0] OP_EQ = 6'd13;
	localparam logic [OP_W-1:0] OP_NE = 6'd14;
	localparam logic [OP_W-1:0] OP_GT = 6'd15;
	localparam logic [OP_W-1:0] OP_GE = 6'd16;
	localparam logic [OP_W-1:0] OP_LT = 6'd17;
	localparam logic [OP_W-1:0] OP_LE = 6'd18;

	// Register map. Vector regions hold one lane word every 4 bytes.
	localparam logic [7:0] ADDR_OP1 = 8'h00;
	localparam logic [7:0] ADDR_OP2 = 8'h40;
	localparam logic [7:0] ADDR_OPCODE = 8'h80;
	localparam logic [7:0] ADDR_CTRL = 8'h84;	// Bit 0 starts an operation.
	localparam logic [7:0] ADDR_STATUS = 8'h88;	// Count in 31:16, done in bit 0.
	localparam logic [7:0] ADDR_RESULT = 8'hC0;

	// A result is either a vector of lane words or a compare mask.
	typedef union packed {
		logic [LANES-1:0][LANE_W-1:0] lanes;
		struct packed {
			logic [VEC_W-LANES-1:0] pad;
			logic [LANES-1:0] mask;	// Bit n belongs to lane n.
		} cmp;
	} vec_result_u;

endpackage

`default_nettype wire
